//--- common/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

	localparam int word_size = 16;
	localparam int num_regs = 4;
	localparam int reg_idx_bits = 2;

	// Opcodes, field [15:12]
	localparam logic [3:0] op_bne = 4'd0;
	localparam logic [3:0] op_beq = 4'd1;
	localparam logic [3:0] op_bgz = 4'd2;
	localparam logic [3:0] op_blz = 4'd3;
	localparam logic [3:0] op_adi = 4'd4;
	localparam logic [3:0] op_ori = 4'd5;
	localparam logic [3:0] op_lhi = 4'd6;
	localparam logic [3:0] op_lwd = 4'd7;
	localparam logic [3:0] op_swd = 4'd8;
	localparam logic [3:0] op_jmp = 4'd9;
	localparam logic [3:0] op_jal = 4'd10;
	localparam logic [3:0] op_rtype = 4'd15;

	// Function codes of the register group
	localparam logic [5:0] func_add = 6'd0;
	localparam logic [5:0] func_sub = 6'd1;
	localparam logic [5:0] func_and = 6'd2;
	localparam logic [5:0] func_orr = 6'd3;
	localparam logic [5:0] func_not = 6'd4;
	localparam logic [5:0] func_tcp = 6'd5;
	localparam logic [5:0] func_shl = 6'd6;
	localparam logic [5:0] func_shr = 6'd7;
	localparam logic [5:0] func_jpr = 6'd25;
	localparam logic [5:0] func_jrl = 6'd26;
	localparam logic [5:0] func_wwd = 6'd28;
	localparam logic [5:0] func_hlt = 6'd29;

	// Jump and link targets this register
	localparam logic [reg_idx_bits-1:0] link_reg = 2'd2;

	// Writeback source select
	localparam logic [1:0] wb_alu = 2'd0;
	localparam logic [1:0] wb_mem = 2'd1;
	localparam logic [1:0] wb_pc = 2'd2;

	// Ten operations, so four bits
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_not,
		alu_tcp,
		alu_shl,
		alu_shr,
		alu_lhi,
		alu_pass_a
	} alu_op_t;

	typedef enum logic [2:0] {
		st_fetch,
		st_decode,
		st_execute,
		st_memory,
		st_writeback,
		st_halted
	} ctrl_state_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [1:0] rd;
		logic [5:0] func;
	} r_form_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [1:0] rs;
		logic [1:0] rt;
		logic [7:0] imm;
	} i_form_t;

	typedef struct packed {
		logic [3:0] opcode;
		logic [11:0] target;
	} j_form_t;

	typedef union packed {
		r_form_t r_form;
		i_form_t i_form;
		j_form_t j_form;
	} instr_t;

endpackage

`default_nettype wire

//--- exec/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu
	import cpu_pkg::*;
(
	input wire logic [word_size-1:0] a,
	input wire logic [word_size-1:0] b,
	input wire instr_t instr,
	input wire alu_op_t alu_op,
	input wire logic alu_src,
	output logic [word_size-1:0] result,
	output logic bcond
);

	logic [word_size-1:0] imm_ext;
	logic [word_size-1:0] b_op;

	// Immediate extension follows the operation
	always_comb begin
		case (alu_op)
			alu_or: imm_ext = {{(word_size-8){1'b0}}, instr.i_form.imm};
			alu_lhi: imm_ext = {instr.i_form.imm, {(word_size-8){1'b0}}};
			default: imm_ext = {{(word_size-8){instr.i_form.imm[7]}}, instr.i_form.imm};
		endcase
	end

	assign b_op = alu_src ? imm_ext : b;

	always_comb begin
		case (alu_op)
			alu_add: result = a + b_op;
			alu_sub: result = a - b_op;
			alu_and: result = a & b_op;
			alu_or: result = a | b_op;
			alu_not: result = ~a;
			alu_tcp: result = ~a + 16'd1;
			alu_shl: result = {a[word_size-2:0], 1'b0};
			// Arithmetic shift keeps the sign
			alu_shr: result = {a[word_size-1], a[word_size-1:1]};
			alu_lhi: result = b_op;
			default: result = a;
		endcase
	end

	// Branch tests on rs and rt
	always_comb begin
		case (instr.i_form.opcode)
			op_bne: bcond = (a != b);
			op_beq: bcond = (a == b);
			op_bgz: bcond = !a[word_size-1] && (a != '0);
			op_blz: bcond = a[word_size-1];
			default: bcond = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

//--- exec/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file
	import cpu_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire logic reg_write,
	input wire logic [reg_idx_bits-1:0] read1,
	input wire logic [reg_idx_bits-1:0] read2,
	input wire logic [reg_idx_bits-1:0] write_reg,
	input wire logic [word_size-1:0] write_data,
	output logic [word_size-1:0] read_a,
	output logic [word_size-1:0] read_b
);

	logic [word_size-1:0] regs [num_regs];

	assign read_a = regs[read1];
	assign read_b = regs[read2];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < num_regs; i++) begin
				regs[i] <= '0;
			end
		end else if (reg_write) begin
			regs[write_reg] <= write_data;
		end
	end

endmodule

`default_nettype wire

//--- fetch/instr_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module instr_fetch
	import cpu_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire logic pc_write,
	input wire logic ir_write,
	input wire logic branch,
	input wire logic jump,
	input wire logic jump_reg,
	input wire logic bcond,
	input wire logic [word_size-1:0] mem_data,
	input wire logic [word_size-1:0] alu_result,
	output logic [word_size-1:0] pc,
	output instr_t instr,
	output logic [word_size-1:0] num_inst,
	input wire logic retire
);

	logic [word_size-1:0] pc_inc;
	logic [word_size-1:0] branch_off;
	logic [word_size-1:0] next_pc;

	assign pc_inc = pc + 16'd1;
	assign branch_off = {{(word_size-8){instr.i_form.imm[7]}}, instr.i_form.imm};

	// Next address; jumps keep the current page of pc
	always_comb begin
		if (jump) begin
			next_pc = {pc[word_size-1:12], instr.j_form.target};
		end else if (jump_reg) begin
			next_pc = alu_result;
		end else if (branch && bcond) begin
			next_pc = pc_inc + branch_off;
		end else begin
			next_pc = pc_inc;
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc <= '0;
		end else if (pc_write) begin
			pc <= next_pc;
		end
	end

	// Instruction word comes straight off the bus
	always_ff @(posedge clk) begin
		if (ir_write) begin
			instr <= instr_t'(mem_data);
		end
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			num_inst <= '0;
		end else if (retire) begin
			num_inst <= num_inst + 16'd1;
		end
	end

endmodule

`default_nettype wire

//--- control/control_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module control_fsm
	import cpu_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire instr_t instr,
	output logic pc_write,
	output logic ir_write,
	output logic reg_write,
	output logic mem_read,
	output logic mem_write,
	output logic out_write,
	output logic retire,
	output logic is_halted,
	output logic i_or_d,
	output logic alu_src,
	output logic branch,
	output logic jump,
	output logic jump_reg,
	output alu_op_t alu_op,
	output logic [1:0] wb_sel,
	output logic [reg_idx_bits-1:0] write_reg
);

	ctrl_state_t state, next_state;
	logic running;
	logic [3:0] opcode;
	logic [5:0] func;
	logic is_rtype, is_branch, is_jump, is_imm, is_link;
	logic is_jpr, is_jrl, is_wwd, is_hlt;

	assign opcode = instr.r_form.opcode;
	assign func = instr.r_form.func;
	assign is_rtype = (opcode == op_rtype);
	assign is_branch = (opcode <= op_blz);
	assign is_jump = (opcode == op_jmp) || (opcode == op_jal);
	assign is_imm = (opcode == op_adi) || (opcode == op_ori) || (opcode == op_lhi);
	assign is_jpr = is_rtype && (func == func_jpr);
	assign is_jrl = is_rtype && (func == func_jrl);
	assign is_wwd = is_rtype && (func == func_wwd);
	assign is_hlt = is_rtype && (func == func_hlt);
	assign is_link = (opcode == op_jal) || is_jrl;
	assign is_halted = (state == st_halted);

	// Operand and writeback selection depend only on the instruction
	always_comb begin
		alu_op = alu_add;
		if (opcode == op_ori) begin
			alu_op = alu_or;
		end else if (opcode == op_lhi) begin
			alu_op = alu_lhi;
		end else if (is_rtype) begin
			case (func)
				func_sub: alu_op = alu_sub;
				func_and: alu_op = alu_and;
				func_orr: alu_op = alu_or;
				func_not: alu_op = alu_not;
				func_tcp: alu_op = alu_tcp;
				func_shl: alu_op = alu_shl;
				func_shr: alu_op = alu_shr;
				func_jpr, func_jrl: alu_op = alu_pass_a;
				default: alu_op = alu_add;
			endcase
		end
	end

	assign alu_src = is_imm || (opcode == op_lwd) || (opcode == op_swd);
	assign wb_sel = is_link ? wb_pc : (opcode == op_lwd) ? wb_mem : wb_alu;
	assign write_reg = is_link ? link_reg :
		(is_imm || opcode == op_lwd) ? instr.i_form.rt : instr.r_form.rd;

	always_comb begin
		next_state = state;
		{pc_write, ir_write, reg_write, mem_read, mem_write} = '0;
		{out_write, retire, i_or_d, branch, jump, jump_reg} = '0;
		case (state)
			st_fetch: begin
				// First cycle out of reset is idle
				if (running) begin
					mem_read = 1'b1;
					ir_write = 1'b1;
					next_state = st_decode;
				end
			end
			st_decode: begin
				if (is_jump) begin
					pc_write = 1'b1;
					jump = 1'b1;
					reg_write = (opcode == op_jal);
					retire = 1'b1;
					next_state = st_fetch;
				end else if (is_hlt) begin
					retire = 1'b1;
					next_state = st_halted;
				end else begin
					next_state = st_execute;
				end
			end
			st_execute: begin
				if (is_branch || is_jpr || is_wwd) begin
					pc_write = 1'b1;
					branch = is_branch;
					jump_reg = is_jpr;
					out_write = is_wwd;
					retire = 1'b1;
					next_state = st_fetch;
				end else if (opcode == op_lwd || opcode == op_swd) begin
					next_state = st_memory;
				end else begin
					next_state = st_writeback;
				end
			end
			st_memory: begin
				i_or_d = 1'b1;
				if (opcode == op_swd) begin
					mem_write = 1'b1;
					pc_write = 1'b1;
					retire = 1'b1;
					next_state = st_fetch;
				end else begin
					mem_read = 1'b1;
					next_state = st_writeback;
				end
			end
			st_writeback: begin
				reg_write = 1'b1;
				pc_write = 1'b1;
				jump_reg = is_jrl;
				retire = 1'b1;
				next_state = st_fetch;
			end
			default: next_state = st_halted;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= st_fetch;
			running <= 1'b0;
		end else begin
			state <= next_state;
			running <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- design/mem_port.sv
`timescale 1ns/1ps
`default_nettype none

module mem_port
	import cpu_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	input wire logic mem_read,
	input wire logic mem_write,
	input wire logic out_write,
	input wire logic i_or_d,
	input wire logic [word_size-1:0] pc,
	input wire logic [word_size-1:0] alu_result,
	input wire logic [word_size-1:0] store_data,
	input wire logic [word_size-1:0] out_data,
	output logic read_m,
	output logic write_m,
	output logic [word_size-1:0] address,
	inout wire [word_size-1:0] data,
	output logic [word_size-1:0] mem_data,
	output logic [word_size-1:0] output_port
);

	assign read_m = mem_read;
	assign write_m = mem_write;
	assign address = i_or_d ? alu_result : pc;

	// Bus released unless storing
	assign data = mem_write ? store_data : {word_size{1'bz}};

	always_ff @(posedge clk) begin
		if (mem_read) begin
			mem_data <= data;
		end
	end

	// Write word sends rs out
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			output_port <= '0;
		end else if (out_write) begin
			output_port <= out_data;
		end
	end

endmodule

`default_nettype wire

//--- design/cpu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu
	import cpu_pkg::*;
(
	input wire logic clk,
	input wire logic reset_n,
	output logic read_m,
	output logic write_m,
	output logic is_halted,
	output logic [word_size-1:0] address,
	output logic [word_size-1:0] num_inst,
	output logic [word_size-1:0] output_port,
	inout wire [word_size-1:0] data
);

	logic pc_write, ir_write, reg_write, mem_read, mem_write, out_write, retire;
	logic i_or_d, alu_src, branch, jump, jump_reg, bcond;
	alu_op_t alu_op;
	logic [1:0] wb_sel;
	logic [reg_idx_bits-1:0] write_reg;
	instr_t instr;
	logic [word_size-1:0] pc, alu_result, read_a, read_b, mem_data, write_data;

	// Link value is the address of the next instruction
	assign write_data = (wb_sel == wb_pc) ? pc + 16'd1 :
		(wb_sel == wb_mem) ? mem_data : alu_result;

	instr_fetch u_fetch (
		.clk(clk), .reset_n(reset_n), .pc_write(pc_write), .ir_write(ir_write),
		.branch(branch), .jump(jump), .jump_reg(jump_reg), .bcond(bcond),
		.mem_data(data), .alu_result(alu_result), .pc(pc), .instr(instr),
		.num_inst(num_inst), .retire(retire)
	);

	control_fsm u_ctrl (
		.clk(clk), .reset_n(reset_n), .instr(instr), .pc_write(pc_write),
		.ir_write(ir_write), .reg_write(reg_write), .mem_read(mem_read),
		.mem_write(mem_write), .out_write(out_write), .retire(retire),
		.is_halted(is_halted), .i_or_d(i_or_d), .alu_src(alu_src), .branch(branch),
		.jump(jump), .jump_reg(jump_reg), .alu_op(alu_op), .wb_sel(wb_sel),
		.write_reg(write_reg)
	);

	register_file u_regs (
		.clk(clk), .reset_n(reset_n), .reg_write(reg_write),
		.read1(instr.r_form.rs), .read2(instr.r_form.rt), .write_reg(write_reg),
		.write_data(write_data), .read_a(read_a), .read_b(read_b)
	);

	alu u_alu (
		.a(read_a), .b(read_b), .instr(instr), .alu_op(alu_op), .alu_src(alu_src),
		.result(alu_result), .bcond(bcond)
	);

	mem_port u_mem (
		.clk(clk), .reset_n(reset_n), .mem_read(mem_read), .mem_write(mem_write),
		.out_write(out_write), .i_or_d(i_or_d), .pc(pc), .alu_result(alu_result),
		.store_data(read_b), .out_data(read_a), .read_m(read_m), .write_m(write_m),
		.address(address), .data(data), .mem_data(mem_data), .output_port(output_port)
	);

endmodule

`default_nettype wire

//--- verif/isa_model.svh
`ifndef ISA_MODEL_SVH
`define ISA_MODEL_SVH

// Executes model_mem one instruction per step and records what the core should show
task automatic run_model();
	logic [15:0] pc, next_pc, ir, a, b, simm, addr, out_val;
	logic [1:0] rs, rt, rd;
	bit done;
	int steps;
	int r;
	pc = '0;
	out_val = '0;
	done = 0;
	steps = 0;
	for (r = 0; r < 4; r++) begin
		model_regs[r] = '0;
	end
	pc_trace.delete();
	out_trace.delete();
	store_addr.delete();
	store_data.delete();
	while (!done && steps < 1000) begin
		ir = model_mem[pc[7:0]];
		rs = ir[11:10];
		rt = ir[9:8];
		rd = ir[7:6];
		a = model_regs[rs];
		b = model_regs[rt];
		simm = {{8{ir[7]}}, ir[7:0]};
		addr = a + simm;
		next_pc = pc + 16'd1;
		pc_trace.push_back(pc);
		case (ir[15:12])
			op_bne: if (a != b) next_pc = pc + 16'd1 + simm;
			op_beq: if (a == b) next_pc = pc + 16'd1 + simm;
			op_bgz: if ($signed(a) > 0) next_pc = pc + 16'd1 + simm;
			op_blz: if ($signed(a) < 0) next_pc = pc + 16'd1 + simm;
			op_adi: model_regs[rt] = a + simm;
			op_ori: model_regs[rt] = a | {8'h00, ir[7:0]};
			op_lhi: model_regs[rt] = {ir[7:0], 8'h00};
			op_lwd: model_regs[rt] = model_mem[addr[7:0]];
			op_swd: begin
				model_mem[addr[7:0]] = b;
				store_addr.push_back(addr);
				store_data.push_back(b);
			end
			op_jmp: next_pc = {pc[15:12], ir[11:0]};
			op_jal: begin
				model_regs[link_reg] = pc + 16'd1;
				next_pc = {pc[15:12], ir[11:0]};
			end
			op_rtype: begin
				case (ir[5:0])
					func_add: model_regs[rd] = a + b;
					func_sub: model_regs[rd] = a - b;
					func_and: model_regs[rd] = a & b;
					func_orr: model_regs[rd] = a | b;
					func_not: model_regs[rd] = ~a;
					func_tcp: model_regs[rd] = -a;
					func_shl: model_regs[rd] = a << 1;
					func_shr: model_regs[rd] = $signed(a) >>> 1;
					func_jpr: next_pc = a;
					func_jrl: begin
						model_regs[link_reg] = pc + 16'd1;
						next_pc = a;
					end
					func_wwd: out_val = a;
					default: done = 1;
				endcase
			end
			default: done = 1;
		endcase
		out_trace.push_back(out_val);
		steps++;
		pc = next_pc;
	end
	model_count = steps;
endtask

`endif

//--- verif/tb_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu
	import cpu_pkg::*;
;

	logic clk;
	logic reset_n;
	logic read_m, write_m, is_halted;
	logic [15:0] address, num_inst, output_port;
	wire [15:0] data;

	logic [15:0] mem [256];
	logic [15:0] model_mem [256];
	logic [15:0] model_regs [4];
	logic [15:0] pc_trace [$];
	logic [15:0] out_trace [$];
	logic [15:0] store_addr [$];
	logic [15:0] store_data [$];
	int model_count;
	int gen_pc;
	integer seed;
	string test_name;
	int test_errors, total_errors, failed_tests, t;

	`include "isa_model.svh"

	cpu i_dut (
		.clk(clk), .reset_n(reset_n), .read_m(read_m), .write_m(write_m),
		.is_halted(is_halted), .address(address), .num_inst(num_inst),
		.output_port(output_port), .data(data)
	);

	always #10 clk = ~clk;

	// Zero-wait memory, read combinationally and written at the edge
	assign data = read_m ? mem[address[7:0]] : 16'hzzzz;

	always @(posedge clk) begin
		if (write_m) begin
			mem[address[7:0]] <= data;
		end
	end

	function automatic int rand_below(int n);
		return $unsigned($random(seed)) % n;
	endfunction

	function automatic logic [15:0] fill_word(int a);
		return 16'((a * 40503) ^ (a << 7) ^ 23117);
	endfunction

	function automatic logic [15:0] enc_r(logic [1:0] rs, logic [1:0] rt, logic [1:0] rd,
		logic [5:0] fn);
		return {op_rtype, rs, rt, rd, fn};
	endfunction

	function automatic logic [15:0] enc_i(logic [3:0] op, logic [1:0] rs, logic [1:0] rt,
		logic [7:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [15:0] enc_j(logic [3:0] op, logic [11:0] target);
		return {op, target};
	endfunction

	// One of the eight register functions or one of the three immediates
	function automatic logic [15:0] random_arith();
		int kind;
		logic [1:0] rs, rt, rd;
		kind = rand_below(11);
		rs = 2'(rand_below(4));
		rt = 2'(rand_below(4));
		rd = 2'(rand_below(4));
		if (kind < 8) begin
			return enc_r(rs, rt, rd, 6'(kind));
		end
		return enc_i(op_adi + 4'(kind - 8), rs, rt, 8'(rand_below(256)));
	endfunction

	task automatic emit(logic [15:0] word);
		mem[gen_pc] = word;
		gen_pc++;
	endtask

	task automatic emit_arith_block();
		logic [15:0] w;
		w = random_arith();
		emit(w);
		emit(enc_r((w[15:12] == op_rtype) ? w[7:6] : w[9:8], 2'd0, 2'd0, func_wwd));
	endtask

	// r3 points into the data area at 128 and above
	task automatic emit_memory_block();
		logic [1:0] rt;
		logic [7:0] offset;
		rt = 2'(rand_below(3));
		offset = 8'(rand_below(64));
		emit(enc_i(op_lhi, 2'd0, 2'd3, 8'd0));
		emit(enc_i(op_ori, 2'd3, 2'd3, 8'(128 + rand_below(64))));
		if (rand_below(2) == 0) begin
			emit(enc_i(op_swd, 2'd3, rt, offset));
		end else begin
			emit(enc_i(op_lwd, 2'd3, rt, offset));
			emit(enc_r(rt, 2'd0, 2'd0, func_wwd));
		end
	endtask

	// Every transfer lands just past the skipped filler
	task automatic emit_branch_block();
		int kind, skip, target;
		kind = rand_below(6);
		skip = 1 + rand_below(3);
		case (kind)
			0: emit(enc_i(4'(rand_below(4)), 2'(rand_below(4)), 2'(rand_below(4)), 8'(skip)));
			1, 2: emit(enc_j(kind == 1 ? op_jmp : op_jal, 12'(gen_pc + 1 + skip)));
			3, 4: begin
				target = gen_pc + 3 + skip;
				emit(enc_i(op_lhi, 2'd0, 2'd1, 8'd0));
				emit(enc_i(op_ori, 2'd1, 2'd1, 8'(target)));
				emit(enc_r(2'd1, 2'd0, 2'd0, kind == 3 ? func_jpr : func_jrl));
			end
			default: skip = 0;
		endcase
		repeat (skip) begin
			emit(random_arith());
		end
		if (kind == 2 || kind == 4) begin
			emit(enc_r(link_reg, 2'd0, 2'd0, func_wwd));
		end else begin
			emit_arith_block();
		end
	endtask

	task automatic build_program(int kind);
		int a, b;
		for (a = 0; a < 256; a++) begin
			mem[a] = fill_word(a);
		end
		gen_pc = 0;
		for (b = 0; b < 12; b++) begin
			if (kind == 0) begin
				emit_arith_block();
			end else if (kind == 1 && rand_below(2) == 0) begin
				emit_memory_block();
			end else if (kind == 1) begin
				emit_arith_block();
			end else begin
				emit_branch_block();
			end
		end
		emit(enc_r(2'd0, 2'd0, 2'd0, func_hlt));
		for (a = 0; a < 256; a++) begin
			model_mem[a] = mem[a];
		end
	endtask

	task automatic report_mismatch(string what, logic [15:0] expected, logic [15:0] actual);
		$display("[FAIL] %s %s: expected %h, actual %h", test_name, what, expected, actual);
		test_errors++;
	endtask

	task automatic report_problem(string what);
		$display("%s: %s", test_name, what);
		test_errors++;
	endtask

	task automatic apply_reset_and_load(int kind);
		int i;
		@(negedge clk);
		reset_n = 1'b0;
		build_program(kind);
		run_model();
		for (i = 0; i < 16; i++) begin
			@(negedge clk);
			if (read_m !== 1'b0 || write_m !== 1'b0 || is_halted !== 1'b0) begin
				report_problem("a strobe or the halt flag is not low during reset");
			end
			if (num_inst !== 16'd0) begin
				report_mismatch("num_inst in reset", 16'd0, num_inst);
			end
			if (output_port !== 16'd0) begin
				report_mismatch("output_port in reset", 16'd0, output_port);
			end
		end
		reset_n = 1'b1;
	endtask

	task automatic run_and_check();
		int cycles, fetch_idx, store_idx, a;
		logic [15:0] last_count;
		bit expect_fetch;
		cycles = 0;
		fetch_idx = 0;
		store_idx = 0;
		last_count = '0;
		expect_fetch = 1;
		while (!is_halted && cycles < 2000) begin
			@(negedge clk);
			cycles++;
			if (read_m && write_m) begin
				report_problem("read_m and write_m are high together");
			end
			// A retired instruction makes the next read a fetch
			if (num_inst !== last_count) begin
				last_count = num_inst;
				expect_fetch = 1;
				if (last_count > out_trace.size()) begin
					report_problem("the core retired more instructions than the model");
				end else if (output_port !== out_trace[last_count - 1]) begin
					report_mismatch($sformatf("output_port after %0d", last_count),
						out_trace[last_count - 1], output_port);
				end
			end
			if (read_m && expect_fetch) begin
				expect_fetch = 0;
				if (fetch_idx >= pc_trace.size()) begin
					report_problem("the core fetched past the model's last instruction");
				end else if (address !== pc_trace[fetch_idx]) begin
					report_mismatch($sformatf("fetch %0d address", fetch_idx),
						pc_trace[fetch_idx], address);
				end
				fetch_idx++;
			end
			if (write_m) begin
				if (store_idx >= store_addr.size()) begin
					report_problem("the core stored more words than the model");
				end else begin
					if (address !== store_addr[store_idx]) begin
						report_mismatch($sformatf("store %0d address", store_idx),
							store_addr[store_idx], address);
					end
					if (data !== store_data[store_idx]) begin
						report_mismatch($sformatf("store %0d data", store_idx),
							store_data[store_idx], data);
					end
				end
				store_idx++;
			end
		end
		if (!is_halted) begin
			report_problem("timed out after 2000 cycles waiting for is_halted");
			return;
		end
		if (num_inst !== 16'(model_count)) begin
			report_mismatch("retired count", 16'(model_count), num_inst);
		end
		if (fetch_idx != pc_trace.size() || store_idx != store_addr.size()) begin
			report_problem("fetch or store count differs from the model");
		end
		repeat (50) begin
			@(negedge clk);
			if (num_inst !== 16'(model_count)) begin
				report_mismatch("num_inst after halt", 16'(model_count), num_inst);
			end
			if (is_halted !== 1'b1) begin
				report_problem("is_halted dropped after the halt instruction");
			end
		end
		for (a = 0; a < 256; a++) begin
			if (mem[a] !== model_mem[a]) begin
				report_mismatch($sformatf("memory word %0d", a), model_mem[a], mem[a]);
			end
		end
	endtask

	initial begin
		clk = 1'b0;
		reset_n = 1'b0;
		seed = 56564;
		total_errors = 0;
		failed_tests = 0;
		for (t = 0; t < 20; t++) begin
			test_errors = 0;
			case (t % 3)
				0: test_name = $sformatf("arith_%0d", t);
				1: test_name = $sformatf("memory_%0d", t);
				default: test_name = $sformatf("branch_%0d", t);
			endcase
			apply_reset_and_load(t % 3);
			run_and_check();
			if (test_errors == 0) begin
				$display("%s: passed, %0d instructions", test_name, model_count);
			end else begin
				$display("%s: failed with %0d mismatches", test_name, test_errors);
				failed_tests++;
			end
			total_errors += test_errors;
		end
		$display("Tests run: 20, failed: %0d, failed checks: %0d", failed_tests, total_errors);
		if (total_errors == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
+incdir+verif
common/cpu_pkg.sv
exec/alu.sv
exec/register_file.sv
fetch/instr_fetch.sv
control/control_fsm.sv
design/mem_port.sv
design/cpu.sv
verif/tb_cpu.sv
